// ==== source/branchPredictMacros.svh ====
/*
  Branch predictor sizing macros
  History length, instruction address width and counter width
  shared by the gshare direction predictor and its tracking pipeline
*/

`ifndef BRANCH_PREDICT_MACROS_SVH
`define BRANCH_PREDICT_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// Global history
////////////////////////////////////////////////////////////////////////

// GHR bits used to index the PHT, also sets table depth to 2**len
// The register itself carries two extra bits for undoing shifts
`define HISTORY_LEN 10

////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////

// Instruction address width
`define PC_WIDTH 32
// Saturating counter width, top bit is the taken guess
`define COUNTER_WIDTH 2

`endif

// ==== source/branchPredictPkg.sv ====
/*
  Branch predictor package
  Shared vector types for addresses, history and table indices,
  plus the saturating counter state encoding
*/

`include "branchPredictMacros.svh"

package branchPredictPkg;

  ////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////

  // Instruction address
  typedef logic [`PC_WIDTH-1:0] pcT;

  // Full GHR with room to undo two speculative shifts
  typedef logic [`HISTORY_LEN+1:0] historyT;

  // PHT address
  typedef logic [`HISTORY_LEN-1:0] tableIndexT;

  ////////////////////////////////////////////////////////////////////////
  // Counter states
  ////////////////////////////////////////////////////////////////////////

  // Upper bit gives the taken guess
  typedef enum logic [`COUNTER_WIDTH-1:0] {
    strongNotTaken = 2'd0,
    weakNotTaken   = 2'd1,
    weakTaken      = 2'd2,
    strongTaken    = 2'd3
  } counterT;

endpackage

// ==== source/predictionTable.sv ====
/*
  Pattern history table
  Array of 2-bit saturating counters with one registered read port
  and one write port, all entries start weakly not taken
*/

`timescale 1ns/1ps

`include "branchPredictMacros.svh"

module predictionTable (
  input  logic                        clk,
  input  logic                        reset,
  // Lookup side
  input  branchPredictPkg::tableIndexT readIndex,
  input  logic                        readEnable,
  output branchPredictPkg::counterT   readCount,
  // Training side
  input  branchPredictPkg::tableIndexT writeIndex,
  input  branchPredictPkg::counterT   writeCount,
  input  logic                        writeEnable
);

  // One entry per history pattern
  localparam int tableDepth = 1 << `HISTORY_LEN;

  branchPredictPkg::counterT counts [tableDepth];

  ////////////////////////////////////////////////////////////////////////
  // Read and write ports
  ////////////////////////////////////////////////////////////////////////

  // Read and write share one block so a same-index collision
  // returns the old entry, the new one shows up next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      // Weakly not taken everywhere, one taken outcome flips it
      for (int i = 0; i < tableDepth; i++) begin
        counts[i] <= branchPredictPkg::weakNotTaken;
      end
      // Guess bit low out of reset
      readCount <= branchPredictPkg::weakNotTaken;
    end else begin
      // Read register holds while fetch is stalled
      if (readEnable) begin
        readCount <= counts[readIndex];
      end
      if (writeEnable) begin
        counts[writeIndex] <= writeCount;
      end
    end
  end

endmodule

// ==== source/predictorPipeline.sv ====
/*
  Predictor tracking pipeline
  Carries PC, predicted class and fetched counter from fetch to execute,
  then trains the counter and flags a wrong direction guess
*/

`timescale 1ns/1ps

`include "branchPredictMacros.svh"

module predictorPipeline (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stallF,
  input  logic                      stallD,
  input  logic                      stallE,
  input  logic                      flushF,
  input  logic                      flushD,
  input  logic                      flushE,
  // Fetch side
  input  branchPredictPkg::pcT      pcNextF,
  input  logic                      predClassF,
  input  branchPredictPkg::counterT predictionF,
  // Resolve side
  input  logic                      branchE,
  input  logic                      takenE,
  // Towards the gshare core
  output logic                      predClassD,
  output logic                      predClassE,
  output branchPredictPkg::pcT      pcE,
  output branchPredictPkg::counterT trainCountE,
  output logic                      trainEnableE,
  output logic                      dirWrongE
);

  branchPredictPkg::pcT      pcF;
  branchPredictPkg::pcT      pcD;
  branchPredictPkg::counterT countD;
  branchPredictPkg::counterT countE;
  logic                      guessE;

  ////////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////////

  // Payload follows the stall only
  always_ff @(posedge clk) begin
    if (!stallF) begin
      pcF <= pcNextF;
    end
    if (!stallD) begin
      pcD    <= pcF;
      countD <= predictionF;
    end
    if (!stallE) begin
      pcE    <= pcD;
      countE <= countD;
    end
  end

  // Class bits are control, flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      predClassD <= 1'b0;
      predClassE <= 1'b0;
    end else begin
      if (flushD) begin
        predClassD <= 1'b0;
      end else if (!stallD) begin
        // A flushed fetch slot enters decode as a non-branch
        predClassD <= predClassF & ~flushF;
      end
      if (flushE) begin
        predClassE <= 1'b0;
      end else if (!stallE) begin
        predClassE <= predClassD;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Execute training
  ////////////////////////////////////////////////////////////////////////

  // Saturating step toward the real outcome
  always_comb begin
    case (countE)
      branchPredictPkg::strongNotTaken:
        trainCountE = takenE ? branchPredictPkg::weakNotTaken : branchPredictPkg::strongNotTaken;
      branchPredictPkg::weakNotTaken:
        trainCountE = takenE ? branchPredictPkg::weakTaken : branchPredictPkg::strongNotTaken;
      branchPredictPkg::weakTaken:
        trainCountE = takenE ? branchPredictPkg::strongTaken : branchPredictPkg::weakNotTaken;
      default:
        trainCountE = takenE ? branchPredictPkg::strongTaken : branchPredictPkg::weakTaken;
    endcase
  end

  // Only real branches train, once, on the cycle execute advances
  assign trainEnableE = branchE & ~stallE;

  // Taken guess of the counter read at fetch
  assign guessE = countE[`COUNTER_WIDTH-1];

  // Direction miss only counts when BTB and decode agree it is a branch
  assign dirWrongE = predClassE & branchE & (guessE ^ takenE);

endmodule

// ==== source/gsharePredictor.sv ====
/*
  Gshare direction predictor
  Speculative GHR with one-hot repair select, PC/history index hashing
  for lookup and training, and the PHT instance
*/

`timescale 1ns/1ps

`include "branchPredictMacros.svh"

module gsharePredictor (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stallF,
  input  logic                      stallE,
  // Lookup
  input  branchPredictPkg::pcT      pcNextF,
  input  logic                      predClassF,
  output branchPredictPkg::counterT predictionF,
  // Tracked classes
  input  logic                      predClassD,
  input  logic                      predClassE,
  // Resolve and training
  input  branchPredictPkg::pcT      pcE,
  input  logic                      branchE,
  input  logic                      takenE,
  input  logic                      dirWrongE,
  input  branchPredictPkg::counterT trainCountE,
  input  logic                      trainEnableE
);

  localparam int historyLen = `HISTORY_LEN;

  branchPredictPkg::historyT    ghr;
  branchPredictPkg::historyT    ghrNext;
  logic [6:0]                   ghrSelect;
  logic                         ghrUpdateEnable;
  branchPredictPkg::tableIndexT ghrLookup;
  branchPredictPkg::tableIndexT ghrTrain;
  branchPredictPkg::tableIndexT readIndex;
  branchPredictPkg::tableIndexT writeIndex;

  // Execute outcome classes
  logic classRightNonBranch;
  logic classWrongBranch;
  logic classWrongNonBranch;
  logic classRightDirWrong;
  logic classRightDirRight;

  ////////////////////////////////////////////////////////////////////////
  // Resolve classification
  ////////////////////////////////////////////////////////////////////////

  assign classRightNonBranch = ~predClassE & ~branchE;
  // Branch the BTB missed, never shifted into the GHR
  assign classWrongBranch    = ~predClassE & branchE;
  // Shifted but not a branch at all
  assign classWrongNonBranch = predClassE & ~branchE;
  assign classRightDirWrong  = predClassE & branchE & dirWrongE;
  assign classRightDirRight  = predClassE & branchE & ~dirWrongE;

  // One-hot GHR select
  // 0 hold, 1 speculative, 2 shift outcome, 3 fix last bit
  // 4 undo one, 5 undo two, 6 undo one then shift outcome
  assign ghrSelect[0] = ~predClassF & (classRightNonBranch | classRightDirRight);
  assign ghrSelect[1] = predClassF & (classRightNonBranch | classRightDirRight);
  assign ghrSelect[2] = classWrongBranch & ~predClassD;
  assign ghrSelect[3] = (classRightDirWrong & ~predClassD) | (classWrongBranch & predClassD);
  assign ghrSelect[4] = classWrongNonBranch & ~predClassD;
  assign ghrSelect[5] = classWrongNonBranch & predClassD;
  assign ghrSelect[6] = classRightDirWrong & predClassD;

  // Repairs follow execute, the speculative shift follows fetch
  assign ghrUpdateEnable = (|ghrSelect[6:2] & ~stallE) | (ghrSelect[1] & ~stallF);

  ////////////////////////////////////////////////////////////////////////
  // Global history register
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ghrSelect)
      7'b000_0010: ghrNext = {ghr[historyLen:0], predictionF[`COUNTER_WIDTH-1]};
      7'b000_0100: ghrNext = {ghr[historyLen:0], takenE};
      // Newest bit belongs to execute, overwrite it
      7'b000_1000: ghrNext = {ghr[historyLen+1:1], takenE};
      7'b001_0000: ghrNext = {1'b0, ghr[historyLen+1:1]};
      7'b010_0000: ghrNext = {2'b00, ghr[historyLen+1:2]};
      // Drop decode's bit, then fix execute's
      7'b100_0000: ghrNext = {1'b0, ghr[historyLen+1:2], takenE};
      default:     ghrNext = ghr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ghr <= '0;
    end else if (ghrUpdateEnable) begin
      ghr <= ghrNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Index hashing
  ////////////////////////////////////////////////////////////////////////

  // Lookup sees a history change landing on this same edge
  assign ghrLookup = ghrUpdateEnable ? ghrNext[historyLen-1:0] : ghr[historyLen-1:0];

  // Training history skips the resolved branch's own shift
  // and a younger one still sitting in decode
  always_comb begin
    case ({predClassE, predClassD})
      2'b00:   ghrTrain = ghr[historyLen-1:0];
      2'b11:   ghrTrain = ghr[historyLen+1:2];
      default: ghrTrain = ghr[historyLen:1];
    endcase
  end

  // Bit 0 of the PC is always zero
  assign readIndex  = ghrLookup ^ pcNextF[historyLen:1];
  assign writeIndex = ghrTrain ^ pcE[historyLen:1];

  ////////////////////////////////////////////////////////////////////////
  // Pattern history table
  ////////////////////////////////////////////////////////////////////////

  predictionTable i_predictionTable (
    .clk         (clk),
    .reset       (reset),
    .readIndex   (readIndex),
    .readEnable  (~stallF),
    .readCount   (predictionF),
    .writeIndex  (writeIndex),
    .writeCount  (trainCountE),
    .writeEnable (trainEnableE)
  );

endmodule

// ==== source/branchPredictor.sv ====
/*
  Branch direction predictor top
  Joins the fetch-to-execute tracking pipeline to the gshare core
*/

`timescale 1ns/1ps

`include "branchPredictMacros.svh"

module branchPredictor (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stallF,
  input  logic                      stallD,
  input  logic                      stallE,
  input  logic                      flushF,
  input  logic                      flushD,
  input  logic                      flushE,
  input  branchPredictPkg::pcT      pcNextF,
  input  logic                      predClassF,
  input  logic                      branchE,
  input  logic                      takenE,
  output branchPredictPkg::counterT predictionF,
  output logic                      dirWrongE
);

  // Tracked fetch info headed for the core
  logic                      predClassD;
  logic                      predClassE;
  branchPredictPkg::pcT      pcE;
  branchPredictPkg::counterT trainCountE;
  logic                      trainEnableE;

  predictorPipeline i_predictorPipeline (
    .clk          (clk),
    .reset        (reset),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .flushF       (flushF),
    .flushD       (flushD),
    .flushE       (flushE),
    .pcNextF      (pcNextF),
    .predClassF   (predClassF),
    .predictionF  (predictionF),
    .branchE      (branchE),
    .takenE       (takenE),
    .predClassD   (predClassD),
    .predClassE   (predClassE),
    .pcE          (pcE),
    .trainCountE  (trainCountE),
    .trainEnableE (trainEnableE),
    .dirWrongE    (dirWrongE)
  );

  gsharePredictor i_gsharePredictor (
    .clk          (clk),
    .reset        (reset),
    .stallF       (stallF),
    .stallE       (stallE),
    .pcNextF      (pcNextF),
    .predClassF   (predClassF),
    .predictionF  (predictionF),
    .predClassD   (predClassD),
    .predClassE   (predClassE),
    .pcE          (pcE),
    .branchE      (branchE),
    .takenE       (takenE),
    .dirWrongE    (dirWrongE),
    .trainCountE  (trainCountE),
    .trainEnableE (trainEnableE)
  );

endmodule

// ==== tb/branchPredictorTb.sv ====
/*
  Branch predictor testbench
  Replays one stimulus line per clock cycle into the direction predictor
  and compares the fetched counter and the direction miss flag
*/

`timescale 1ns/1ps

module branchPredictorTb;

  ////////////////////////////////////////////////////////////////////////
  // Constants and DUT signals
  ////////////////////////////////////////////////////////////////////////

  localparam int    clockPeriod  = 10;
  localparam int    resetCycles  = 8;
  localparam int    fieldCount   = 13;
  localparam int    marginCycles = 20;
  localparam string stimulusPath = "tb/predictorStimulus.txt";

  logic                      clk;
  logic                      reset;
  logic                      stallF;
  logic                      stallD;
  logic                      stallE;
  logic                      flushF;
  logic                      flushD;
  logic                      flushE;
  branchPredictPkg::pcT      pcNextF;
  logic                      predClassF;
  logic                      branchE;
  logic                      takenE;
  branchPredictPkg::counterT predictionF;
  logic                      dirWrongE;

  // Flattened stimulus with fieldCount words per line
  logic [31:0] stimulus [$];
  int          lineCount;
  bit          stimulusLoaded;

  branchPredictor i_branchPredictor (
    .clk         (clk),
    .reset       (reset),
    .stallF      (stallF),
    .stallD      (stallD),
    .stallE      (stallE),
    .flushF      (flushF),
    .flushD      (flushD),
    .flushE      (flushE),
    .pcNextF     (pcNextF),
    .predClassF  (predClassF),
    .branchE     (branchE),
    .takenE      (takenE),
    .predictionF (predictionF),
    .dirWrongE   (dirWrongE)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #(clockPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////

  // Compare one DUT output against its expected value
  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED time %0t signal %s actual %0h expected %0h",
               $time, signalName, actual, expected);
      $display("sim failed");
      $fatal(1, "Mismatch on %s", signalName);
    end
  endtask

  // Read every data line and skip comment lines starting with #
  task automatic loadStimulus(output string problem);
    int          fd;
    int          status;
    int          count;
    string       lineText;
    logic [31:0] v [fieldCount];
    problem = "";
    fd = $fopen(stimulusPath, "r");
    if (fd == 0) begin
      problem = "could not open the stimulus file";
    end else begin
      while (problem == "" && !$feof(fd)) begin
        lineText = "";
        status = $fgets(lineText, fd);
        if (status > 0 && lineText.len() > 1 && lineText[0] != "#") begin
          count = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                          v[7], v[8], v[9], v[10], v[11], v[12]);
          if (count != fieldCount) begin
            problem = $sformatf("malformed stimulus line: %s", lineText);
          end else begin
            for (int k = 0; k < fieldCount; k++) begin
              stimulus.push_back(v[k]);
            end
          end
        end
      end
      $fclose(fd);
      if (problem == "" && stimulus.size() == 0) begin
        problem = "the stimulus file holds no data lines";
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    longint limitNs;
    wait (stimulusLoaded);
    limitNs = longint'(lineCount + resetCycles + marginCycles) * clockPeriod;
    #(limitNs);
    $display("Timeout: the stimulus replay did not finish in time");
    $display("sim failed");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus replay
  ////////////////////////////////////////////////////////////////////////

  initial begin : replay
    string problem;
    int    base;
    reset      = 1'b1;
    stallF     = 1'b0;
    stallD     = 1'b0;
    stallE     = 1'b0;
    flushF     = 1'b0;
    flushD     = 1'b0;
    flushE     = 1'b0;
    pcNextF    = '0;
    predClassF = 1'b0;
    branchE    = 1'b0;
    takenE     = 1'b0;
    stimulusLoaded = 1'b0;
    loadStimulus(problem);
    if (problem != "") begin
      $display("Stimulus error: %s", problem);
      $display("sim failed");
      $fatal(1, "Stimulus file problem");
    end else begin
      lineCount = stimulus.size() / fieldCount;
      stimulusLoaded = 1'b1;
      repeat (resetCycles) @(posedge clk);
      #1 reset = 1'b0;
      for (int lineIdx = 0; lineIdx < lineCount; lineIdx++) begin
        base = lineIdx * fieldCount;
        // Inputs change shortly after the edge
        @(posedge clk);
        #1;
        stallF     = stimulus[base][0];
        stallD     = stimulus[base + 1][0];
        stallE     = stimulus[base + 2][0];
        flushF     = stimulus[base + 3][0];
        flushD     = stimulus[base + 4][0];
        flushE     = stimulus[base + 5][0];
        pcNextF    = stimulus[base + 6];
        predClassF = stimulus[base + 7][0];
        branchE    = stimulus[base + 8][0];
        takenE     = stimulus[base + 9][0];
        // Sample late in the cycle since dirWrongE is combinational
        #5;
        if (stimulus[base + 12][1]) begin
          checkValue("predictionF", {30'b0, predictionF}, stimulus[base + 10]);
        end
        if (stimulus[base + 12][0]) begin
          checkValue("dirWrongE", {31'b0, dirWrongE}, stimulus[base + 11]);
        end
      end
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+source
source/branchPredictPkg.sv
source/predictionTable.sv
source/predictorPipeline.sv
source/gsharePredictor.sv
source/branchPredictor.sv
tb/branchPredictorTb.sv

// ==== Makefile ====
# Verilator build and run of the branch predictor testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = branchPredictorTb
FILELIST  = files.f

.PHONY: sim clean

# A $fatal in the testbench makes the binary, and so make, fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb/predictorStimulus.txt ====
# stallF stallD stallE flushF flushD flushE pcNextF predClassF branchE takenE
# expPredictionF expDirWrongE checkMask(bit1 prediction, bit0 dirWrong), all hex
# Reset state, every entry weakly not taken
0 0 0 0 0 0 00001000 0 0 0 1 0 3
0 0 0 0 0 0 00002004 0 0 0 1 0 3
0 0 0 0 0 0 00000040 0 0 0 1 0 3
0 0 0 0 0 0 00000ffc 0 0 0 1 0 3
# Predicted branch at 0x200 guesses not taken, resolves taken
0 0 0 0 0 0 00000200 0 0 0 1 0 3
0 0 0 0 0 0 00000000 1 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 1 3
# Unpredicted taken branches fill the history with ones, no miss flag
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
0 0 0 0 0 0 00000000 0 1 1 1 0 3
# Branch at 0x404 trained taken under a steady all-ones history
0 0 0 0 0 0 00000404 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 1 1 2 0 3
0 0 0 0 0 0 00000404 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 1 1 2 0 3
0 0 0 0 0 0 00000404 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 0 0 3 0 3
0 0 0 0 0 0 00000000 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 1 1 2 0 3
0 0 0 0 0 0 00000404 0 0 0 2 0 3
0 0 0 0 0 0 00000000 0 0 0 3 0 3
# One not-taken outcome changes the history, 0x404 now hits a fresh entry
0 0 0 0 0 0 00000000 0 1 0 2 0 3
0 0 0 0 0 0 00000404 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
# 0x406 hashes onto the trained entry, then fetch stalls
0 0 0 0 0 0 00000406 0 0 0 1 0 3
1 0 0 0 0 0 00000000 0 0 0 3 0 3
1 0 0 0 0 0 00001000 0 0 0 3 0 3
0 0 0 0 0 0 00000000 0 0 0 3 0 3
# Predicted branch flushed on its way into decode
0 0 0 0 0 0 00000406 0 0 0 1 0 3
0 0 0 0 1 0 00000000 1 0 0 3 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
0 0 0 0 0 0 00000000 0 0 0 1 0 3
